// ==== verilog/pipe_ctrl_pkg.sv ====
/*
 * Shared types and constants for the exception and stall control subsystem.
 * Stage masks are indexed IF at bit 0 up to WB at bit 4.
 * Only the CP0 fields used by this subsystem are modeled. ERL, ErrorEPC,
 * timers and bus errors are not covered.
 */
`default_nettype none

package pipe_ctrl_pkg;

    localparam int NUM_STAGES = 5;
    localparam int STG_MEM    = 3;   // Interrupts are taken on the MEM PC

    typedef logic [NUM_STAGES-1:0] stage_mask_t;

    localparam stage_mask_t MASK_NONE = 5'b00000;
    localparam stage_mask_t MASK_ALL  = 5'b11111;

    // Cause.ExcCode values, ERET is internal only
    typedef enum logic [4:0] {
        EXC_INTR = 5'd0,
        EXC_TLBM = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYSC = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_CPU  = 5'd11,
        EXC_OV   = 5'd12,
        EXC_TRAP = 5'd13,
        EXC_ERET = 5'd31
    } exc_code_t;

    typedef struct packed {
        logic      valid;
        exc_code_t code;
        logic      tlb_refill;   // TLBL/TLBS with no matching entry
    } exc_req_t;

    typedef struct packed {
        logic        valid;
        exc_code_t   code;
        logic        tlb_refill;
        logic [31:0] epc;              // Faulting PC
        logic        bad_addr_valid;   // Reserved, always zero
    } exc_rec_t;

    // CP0 fields seen by the controller
    typedef struct packed {
        logic        bev;
        logic        exl;
        logic        iv;
        logic [31:0] epc;
    } cp0_state_t;

    typedef struct packed {
        logic        en;
        logic [1:0]  sel;    // 0 Status, 1 Cause, 2 EPC
        logic [31:0] data;
    } cp0_wr_t;

    localparam logic [1:0] CP0_SEL_STATUS = 2'd0;
    localparam logic [1:0] CP0_SEL_CAUSE  = 2'd1;
    localparam logic [1:0] CP0_SEL_EPC    = 2'd2;

    // Exception vectors
    localparam logic [31:0] BASE_NML    = 32'h8000_0000;
    localparam logic [31:0] BASE_BTS    = 32'hBFC0_0200;
    localparam logic [31:0] OFF_GEN     = 32'h0000_0180;
    localparam logic [31:0] OFF_SPINT   = 32'h0000_0200;
    localparam logic [31:0] NML_GEN_EXC = BASE_NML + OFF_GEN;
    localparam logic [31:0] NML_SP_INTR = BASE_NML + OFF_SPINT;
    localparam logic [31:0] BTS_GEN_EXC = BASE_BTS + OFF_GEN;
    localparam logic [31:0] BTS_SP_INTR = BASE_BTS + OFF_SPINT;

    // CP0 bit positions
    localparam int STATUS_IE     = 0;
    localparam int STATUS_EXL    = 1;
    localparam int STATUS_IM_LO  = 10;
    localparam int STATUS_IM_W   = 6;
    localparam int STATUS_BEV    = 22;
    localparam int CAUSE_IV      = 23;
    localparam int CAUSE_IP_LO   = 10;
    localparam int CAUSE_CODE_LO = 2;

    localparam logic [31:0] STATUS_RESET = 32'h0040_0000;   // BEV set
    localparam logic [31:0] STATUS_WMASK = 32'h0040_FC03;   // BEV, IM, EXL, IE
    localparam logic [31:0] CAUSE_WMASK  = 32'h0080_0000;   // IV only

endpackage

`default_nettype wire

// ==== verilog/exc_collect.sv ====
/*
 * Picks one exception source per cycle and registers it as the record.
 * Priority is pending interrupt, then the oldest stage request, then ERET.
 * While a record is valid the pipeline is flushing and new requests are
 * dropped, so a record can be valid at most every other cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module exc_collect (
    input  wire                                                 clk,
    input  wire                                                 arst_n,
    input  pipe_ctrl_pkg::exc_req_t [pipe_ctrl_pkg::NUM_STAGES-1:0] exc_req,
    input  wire [pipe_ctrl_pkg::NUM_STAGES-1:0][31:0]           stage_pc,
    input  wire                                                 eret,
    input  wire [5:0]                                           hw_int,
    input  wire [31:0]                                          cp0_status,
    output pipe_ctrl_pkg::exc_rec_t                             exc_rec
);

    import pipe_ctrl_pkg::*;

    logic        int_pend;
    logic        req_hit;
    exc_req_t    req_sel;
    logic [31:0] req_pc;
    exc_rec_t    win;

    logic        rec_valid;
    exc_code_t   rec_code;
    logic        rec_refill;
    logic [31:0] rec_epc;

    // Unmasked interrupt, only outside exception level
    assign int_pend = (|(hw_int & cp0_status[STATUS_IM_LO +: STATUS_IM_W]))
                      && cp0_status[STATUS_IE] && !cp0_status[STATUS_EXL];

    // Later stages overwrite earlier ones, so WB ends up winning
    always_comb begin
        req_hit = 1'b0;
        req_sel = '0;
        req_pc  = '0;
        for (int i = 0; i < NUM_STAGES; i++) begin
            if (exc_req[i].valid) begin
                req_hit = 1'b1;
                req_sel = exc_req[i];
                req_pc  = stage_pc[i];
            end
        end
    end

    always_comb begin
        win = '0;
        if (int_pend) begin
            win.valid = 1'b1;
            win.code  = EXC_INTR;
            win.epc   = stage_pc[STG_MEM];
        end else if (req_hit) begin
            win.valid      = 1'b1;
            win.code       = req_sel.code;
            win.tlb_refill = req_sel.tlb_refill;
            win.epc        = req_pc;
        end else if (eret) begin
            win.valid = 1'b1;
            win.code  = EXC_ERET;
            win.epc   = stage_pc[STG_MEM];   // Unused, EPC comes from CP0
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= !rec_valid && win.valid;   // One dead cycle after a record
        end
    end

    always_ff @(posedge clk) begin
        if (!rec_valid && win.valid) begin
            rec_code   <= win.code;
            rec_refill <= win.tlb_refill;
            rec_epc    <= win.epc;
        end
    end

    always_comb begin
        exc_rec                = '0;
        exc_rec.valid          = rec_valid;
        exc_rec.code           = rec_code;
        exc_rec.tlb_refill     = rec_refill;
        exc_rec.epc            = rec_epc;
        exc_rec.bad_addr_valid = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verilog/cp0_regs.sv ====
/*
 * Status, Cause and EPC of CP0.
 * Software writes land at the next edge; an exception or ERET update to the
 * same register at that edge takes precedence over the write.
 * Cause.IP follows hw_int with one cycle of delay and is not writable.
 * cp0_view always shows the values from before this cycle's update.
 */
`timescale 1ns/100ps
`default_nettype none

module cp0_regs (
    input  wire                       clk,
    input  wire                       arst_n,
    input  pipe_ctrl_pkg::exc_rec_t   exc_rec,
    input  wire [5:0]                 hw_int,
    input  pipe_ctrl_pkg::cp0_wr_t    cp0_wr,
    output logic [31:0]               cp0_status,
    output logic [31:0]               cp0_cause,
    output logic [31:0]               cp0_epc,
    output pipe_ctrl_pkg::cp0_state_t cp0_view
);

    import pipe_ctrl_pkg::*;

    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] epc_q;
    logic [31:0] status_nxt;
    logic [31:0] cause_nxt;
    logic [31:0] epc_nxt;
    logic        exc_take;
    logic        exc_ret;

    assign exc_take = exc_rec.valid && (exc_rec.code != EXC_ERET);
    assign exc_ret  = exc_rec.valid && (exc_rec.code == EXC_ERET);

    always_comb begin
        status_nxt = status_q;
        cause_nxt  = cause_q;
        epc_nxt    = epc_q;

        if (cp0_wr.en) begin
            case (cp0_wr.sel)
                CP0_SEL_STATUS: status_nxt = cp0_wr.data & STATUS_WMASK;
                CP0_SEL_CAUSE: begin
                    cause_nxt = (cause_q & ~CAUSE_WMASK) | (cp0_wr.data & CAUSE_WMASK);
                end
                CP0_SEL_EPC:    epc_nxt = cp0_wr.data;
                default:        ;   // Unmapped select ignored
            endcase
        end

        if (exc_take) begin
            status_nxt             = status_q;
            status_nxt[STATUS_EXL] = 1'b1;
            cause_nxt              = cause_q;
            cause_nxt[CAUSE_CODE_LO +: $bits(exc_code_t)] = exc_rec.code;
            // Nested exception keeps the original return address
            if (!status_q[STATUS_EXL]) begin
                epc_nxt = exc_rec.epc;
            end
        end else if (exc_ret) begin
            status_nxt             = status_q;
            status_nxt[STATUS_EXL] = 1'b0;
        end

        cause_nxt[CAUSE_IP_LO +: STATUS_IM_W] = hw_int;   // IP tracks pins every cycle
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_q <= STATUS_RESET;
            cause_q  <= '0;
            epc_q    <= '0;
        end else begin
            status_q <= status_nxt;
            cause_q  <= cause_nxt;
            epc_q    <= epc_nxt;
        end
    end

    // MFC0 read values
    assign cp0_status = status_q;
    assign cp0_cause  = cause_q;
    assign cp0_epc    = epc_q;

    always_comb begin
        cp0_view     = '0;
        cp0_view.bev = status_q[STATUS_BEV];
        cp0_view.exl = status_q[STATUS_EXL];
        cp0_view.iv  = cause_q[CAUSE_IV];
        cp0_view.epc = epc_q;
    end

endmodule

`default_nettype wire

// ==== verilog/pipe_ctrl.sv ====
/*
 * Stall and flush masks plus the redirect address, fully combinational.
 * A valid exception record flushes every stage and overrides stall requests.
 * Without a record the oldest requesting stage sets the stall boundary.
 * flush_pc is zero whenever there is no record.
 */
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl (
    input  pipe_ctrl_pkg::stage_mask_t stall_req,
    input  pipe_ctrl_pkg::exc_rec_t    exc_rec,
    input  pipe_ctrl_pkg::cp0_state_t  cp0_view,
    output pipe_ctrl_pkg::stage_mask_t stall,
    output pipe_ctrl_pkg::stage_mask_t flush,
    output logic [31:0]                flush_pc
);

    import pipe_ctrl_pkg::*;

    logic bev;
    logic exl;
    logic iv;
    logic is_refill;

    assign bev = cp0_view.bev;
    assign exl = cp0_view.exl;
    assign iv  = cp0_view.iv;

    // Refill vectoring only for TLB load/store misses
    assign is_refill = exc_rec.tlb_refill &&
                       ((exc_rec.code == EXC_TLBL) || (exc_rec.code == EXC_TLBS));

    always_comb begin
        stall    = MASK_NONE;
        flush    = MASK_NONE;
        flush_pc = '0;

        if (exc_rec.valid) begin
            flush = MASK_ALL;   // Whole pipe dies, nothing stalls

            if (exc_rec.code == EXC_ERET) begin
                flush_pc = cp0_view.epc;
            end else if (exc_rec.code == EXC_INTR) begin
                case ({bev, iv})
                    2'b00:   flush_pc = NML_GEN_EXC;
                    2'b01:   flush_pc = NML_SP_INTR;
                    2'b10:   flush_pc = BTS_GEN_EXC;
                    default: flush_pc = BTS_SP_INTR;
                endcase
            end else if (is_refill) begin
                // Refill handler at base unless already at exception level
                case ({bev, exl})
                    2'b00:   flush_pc = BASE_NML;
                    2'b01:   flush_pc = NML_GEN_EXC;
                    2'b10:   flush_pc = BASE_BTS;
                    default: flush_pc = BTS_GEN_EXC;
                endcase
            end else begin
                flush_pc = bev ? BTS_GEN_EXC : NML_GEN_EXC;
            end
        end else begin
            casez (stall_req)
                5'b1????: begin   // WB
                    stall = 5'b11111;
                end
                5'b01???: begin   // MEM
                    stall = 5'b01111;
                    flush = 5'b10000;
                end
                5'b001?0,
                5'b00??1: begin   // EX, or IF with nothing older
                    stall = 5'b00111;
                    flush = 5'b01000;
                end
                5'b00010: begin   // ID alone
                    stall = 5'b00011;
                    flush = 5'b00100;
                end
                default: begin
                    stall = MASK_NONE;
                    flush = MASK_NONE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/exc_ctrl_top.sv ====
/*
 * Exception and stall control top level.
 * Requests and stall requests are plain levels sampled every cycle, with no
 * handshake. CP0 outputs are the current register values for MFC0.
 */
`timescale 1ns/100ps
`default_nettype none

module exc_ctrl_top (
    input  wire                                                 clk,
    input  wire                                                 arst_n,
    input  pipe_ctrl_pkg::stage_mask_t                          stall_req,
    input  pipe_ctrl_pkg::exc_req_t [pipe_ctrl_pkg::NUM_STAGES-1:0] exc_req,
    input  wire [pipe_ctrl_pkg::NUM_STAGES-1:0][31:0]           stage_pc,
    input  wire                                                 eret,
    input  wire [5:0]                                           hw_int,
    input  pipe_ctrl_pkg::cp0_wr_t                              cp0_wr,
    output pipe_ctrl_pkg::stage_mask_t                          stall,
    output pipe_ctrl_pkg::stage_mask_t                          flush,
    output logic [31:0]                                         flush_pc,
    output logic [31:0]                                         cp0_status,
    output logic [31:0]                                         cp0_cause,
    output logic [31:0]                                         cp0_epc
);

    import pipe_ctrl_pkg::*;

    exc_rec_t   exc_rec;
    cp0_state_t cp0_view;

    exc_collect exc_collect_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .exc_req    (exc_req),
        .stage_pc   (stage_pc),
        .eret       (eret),
        .hw_int     (hw_int),
        .cp0_status (cp0_status),   // IE, EXL, IM for interrupt masking
        .exc_rec    (exc_rec)
    );

    cp0_regs cp0_regs_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .exc_rec    (exc_rec),
        .hw_int     (hw_int),
        .cp0_wr     (cp0_wr),
        .cp0_status (cp0_status),
        .cp0_cause  (cp0_cause),
        .cp0_epc    (cp0_epc),
        .cp0_view   (cp0_view)
    );

    pipe_ctrl pipe_ctrl_inst (
        .stall_req (stall_req),
        .exc_rec   (exc_rec),
        .cp0_view  (cp0_view),
        .stall     (stall),
        .flush     (flush),
        .flush_pc  (flush_pc)
    );

endmodule

`default_nettype wire

// ==== dv/exc_ctrl_chk.sv ====
/*
 * Concurrent checks on the stall and flush masks.
 * Sampled on the top level clock, since the controller is combinational.
 * All checks are off while arst_n is low.
 */
`timescale 1ns/100ps
`default_nettype none

module exc_ctrl_chk (
    input  wire                        clk,
    input  wire                        arst_n,
    input  pipe_ctrl_pkg::stage_mask_t stall,
    input  pipe_ctrl_pkg::stage_mask_t flush,
    input  pipe_ctrl_pkg::exc_rec_t    exc_rec
);

    import pipe_ctrl_pkg::*;

    exc_no_stall: assert property (@(posedge clk) disable iff (!arst_n)
        exc_rec.valid |-> (stall == MASK_NONE))
        else $error("stall is set while an exception record is valid");

    // Stall boundary always grows up from IF
    stall_from_if: assert property (@(posedge clk) disable iff (!arst_n)
        stall inside {5'b00000, 5'b00001, 5'b00011, 5'b00111, 5'b01111, 5'b11111})
        else $error("stall mask is not contiguous from IF");

    no_flush_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
        !exc_rec.valid |-> ((stall & flush) == MASK_NONE))
        else $error("a stage is both stalled and flushed without an exception");

endmodule

bind exc_ctrl_top exc_ctrl_chk exc_ctrl_chk_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .stall   (stall),
    .flush   (flush),
    .exc_rec (exc_rec)
);

`default_nettype wire

// ==== dv/exc_ctrl_tb.sv ====
/*
 * Random testbench for exc_ctrl_top with a cycle-level reference model.
 * Inputs change on the rising edge. Outputs and CP0 reads are compared on
 * the falling edge. Four phases each open with directed Status and Cause
 * writes that set BEV and IV, followed by random traffic.
 */
`timescale 1ns/100ps
`default_nettype none

module exc_ctrl_tb;

    import pipe_ctrl_pkg::*;

    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 10;
    localparam int PHASE_CYCLES   = 1000;
    localparam int NUM_PHASES     = 4;
    localparam int TIMEOUT_CYCLES = PHASE_CYCLES * NUM_PHASES + 1000;

    logic                        clk = 1'b0;
    logic                        arst_n;
    stage_mask_t                 stall_req;
    exc_req_t [NUM_STAGES-1:0]   exc_req;
    logic [NUM_STAGES-1:0][31:0] stage_pc;
    logic                        eret;
    logic [5:0]                  hw_int;
    cp0_wr_t                     cp0_wr;
    stage_mask_t                 stall;
    stage_mask_t                 flush;
    logic [31:0]                 flush_pc;
    logic [31:0]                 cp0_status;
    logic [31:0]                 cp0_cause;
    logic [31:0]                 cp0_epc;

    logic [31:0] rng;
    int          mismatch_count;
    int          other_count;
    int          taken_by_mode [4];   // Exceptions taken, indexed by {BEV, IV}

    // Reference model state
    logic        m_rec_valid;
    logic [4:0]  m_rec_code;
    logic        m_rec_refill;
    logic [31:0] m_rec_epc;
    logic [31:0] m_status;
    logic [31:0] m_cause;
    logic [31:0] m_epc;

    exc_ctrl_top exc_ctrl_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .stall_req  (stall_req),
        .exc_req    (exc_req),
        .stage_pc   (stage_pc),
        .eret       (eret),
        .hw_int     (hw_int),
        .cp0_wr     (cp0_wr),
        .stall      (stall),
        .flush      (flush),
        .flush_pc   (flush_pc),
        .cp0_status (cp0_status),
        .cp0_cause  (cp0_cause),
        .cp0_epc    (cp0_epc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x   = rng;
        x   = x ^ (x << 13);
        x   = x ^ (x >> 17);
        x   = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // Stage exception codes, INTR and ERET never come from a stage
    function automatic exc_code_t pick_code(input logic [3:0] k);
        case (k)
            4'd0:    return EXC_TLBM;
            4'd1,
            4'd11:   return EXC_TLBL;
            4'd2,
            4'd12:   return EXC_TLBS;
            4'd3:    return EXC_ADEL;
            4'd4:    return EXC_ADES;
            4'd5:    return EXC_SYSC;
            4'd6:    return EXC_BP;
            4'd7:    return EXC_RI;
            4'd8:    return EXC_CPU;
            4'd10:   return EXC_TRAP;
            default: return EXC_OV;
        endcase
    endfunction

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] rs;
        logic [31:0] wr_data;
        logic [4:0]  valid_mask;
        @(posedge clk);
        r          = next_rand();
        r2         = next_rand();
        wr_data    = next_rand();
        valid_mask = 5'd0;
        if (r[8:6] == 3'd0) begin   // About 1 in 8 cycles
            valid_mask = (r2[4:0] == 5'd0) ? 5'b00100 : r2[4:0];
        end
        stall_req <= r[0] ? 5'd0 : r[5:1];
        for (int i = 0; i < NUM_STAGES; i++) begin
            rs = next_rand();
            exc_req[i]  <= '{valid: valid_mask[i], code: pick_code(rs[3:0]), tlb_refill: rs[4]};
            stage_pc[i] <= {rs[31:2], 2'b00};
        end
        eret   <= (r[12:9] == 4'd0);
        hw_int <= (r[17:13] == 5'd0) ? (6'd1 << r[20:18]) : 6'd0;   // Sparse
        cp0_wr <= '{en: ((r2 % 32'd10) == 32'd0), sel: r2[6:5], data: wr_data};
    endtask

    task automatic drive_idle(input cp0_wr_t wr);
        @(posedge clk);
        stall_req <= '0;
        exc_req   <= '0;
        eret      <= 1'b0;
        hw_int    <= '0;
        cp0_wr    <= wr;
    endtask

    // One clock of the collector and CP0 registers, on the inputs before this edge
    task automatic model_step();
        logic        int_pend;
        logic        win_valid;
        logic [4:0]  win_code;
        logic        win_refill;
        logic [31:0] win_epc;
        logic [31:0] st;
        logic [31:0] ca;
        logic [31:0] ep;
        logic        take;
        int_pend   = (|(hw_int & m_status[15:10])) && m_status[0] && !m_status[1];
        win_valid  = 1'b0;
        win_code   = 5'd0;
        win_refill = 1'b0;
        win_epc    = 32'd0;
        if (int_pend) begin
            win_valid = 1'b1;
            win_epc   = stage_pc[3];   // MEM PC
        end else begin
            for (int i = NUM_STAGES - 1; i >= 0; i--) begin   // Oldest stage first
                if (exc_req[i].valid && !win_valid) begin
                    win_valid  = 1'b1;
                    win_code   = exc_req[i].code;
                    win_refill = exc_req[i].tlb_refill;
                    win_epc    = stage_pc[i];
                end
            end
            if (!win_valid && eret) begin
                win_valid = 1'b1;
                win_code  = 5'd31;
            end
        end

        st = m_status;
        ca = m_cause;
        ep = m_epc;
        if (cp0_wr.en) begin
            case (cp0_wr.sel)
                2'd0:    st = cp0_wr.data & 32'h0040_FC03;
                2'd1:    ca = {ca[31:24], cp0_wr.data[23], ca[22:0]};
                2'd2:    ep = cp0_wr.data;
                default: ;
            endcase
        end
        take = m_rec_valid && (m_rec_code != 5'd31);
        if (take) begin
            taken_by_mode[{m_status[22], m_cause[23]}]++;
            st = m_status | 32'h0000_0002;
            ca = {m_cause[31:7], m_rec_code, m_cause[1:0]};
            if (!m_status[1]) begin
                ep = m_rec_epc;   // Nested exception keeps EPC
            end
        end else if (m_rec_valid) begin
            st = m_status & ~32'h0000_0002;   // ERET
        end
        ca[15:10] = hw_int;

        if (!m_rec_valid && win_valid) begin
            m_rec_code   = win_code;
            m_rec_refill = win_refill;
            m_rec_epc    = win_epc;
        end
        m_rec_valid = !m_rec_valid && win_valid;
        m_status    = st;
        m_cause     = ca;
        m_epc       = ep;
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            mismatch_count++;
            $display("mismatch %s: expected 0x%h actual 0x%h at %0t",
                     name, exp_val, act_val, $time);
        end
    endtask

    task automatic check_outputs();
        logic [4:0]  exp_stall;
        logic [4:0]  exp_flush;
        logic [31:0] exp_pc;
        logic [31:0] base;
        base      = m_status[22] ? BASE_BTS : BASE_NML;
        exp_stall = 5'b00000;
        exp_flush = 5'b00000;
        exp_pc    = 32'd0;
        if (m_rec_valid) begin
            exp_flush = 5'b11111;
            if (m_rec_code == 5'd31) begin
                exp_pc = m_epc;
            end else if (m_rec_code == 5'd0) begin
                exp_pc = base + (m_cause[23] ? OFF_SPINT : OFF_GEN);
            end else if (m_rec_refill && (m_rec_code == 5'd2 || m_rec_code == 5'd3)) begin
                exp_pc = m_status[1] ? base + OFF_GEN : base;
            end else begin
                exp_pc = base + OFF_GEN;
            end
        end else if (stall_req[4]) begin
            exp_stall = 5'b11111;
        end else if (stall_req[3]) begin
            exp_stall = 5'b01111;
            exp_flush = 5'b10000;
        end else if (stall_req[2] || stall_req[0]) begin
            exp_stall = 5'b00111;
            exp_flush = 5'b01000;
        end else if (stall_req[1]) begin
            exp_stall = 5'b00011;
            exp_flush = 5'b00100;
        end
        compare_word("stall", {27'd0, exp_stall}, {27'd0, stall});
        compare_word("flush", {27'd0, exp_flush}, {27'd0, flush});
        compare_word("flush_pc", exp_pc, flush_pc);
        compare_word("cp0_status", m_status, cp0_status);
        compare_word("cp0_cause", m_cause, cp0_cause);
        compare_word("cp0_epc", m_epc, cp0_epc);
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_rec_valid  = 1'b0;
            m_rec_code   = 5'd0;
            m_rec_refill = 1'b0;
            m_rec_epc    = 32'd0;
            m_status     = 32'h0040_0000;   // BEV set
            m_cause      = 32'd0;
            m_epc        = 32'd0;
            for (int m = 0; m < 4; m++) begin
                taken_by_mode[m] = 0;
            end
        end else begin
            model_step();
        end
    end

    always @(negedge clk) begin
        check_outputs();
    end

    initial begin
        rng            = 32'h4b37_00c2;
        mismatch_count = 0;
        other_count    = 0;
        arst_n         = 1'b0;
        stall_req      = '0;
        exc_req        = '0;
        stage_pc       = '0;
        eret           = 1'b0;
        hw_int         = '0;
        cp0_wr         = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        for (int p = 0; p < NUM_PHASES; p++) begin
            drive_idle('0);   // Let any record drain before the directed writes
            drive_idle('0);
            drive_idle('{en: 1'b1, sel: CP0_SEL_STATUS,
                         data: (p[1] ? 32'h0040_FC01 : 32'h0000_FC01)});
            drive_idle('{en: 1'b1, sel: CP0_SEL_CAUSE,
                         data: (p[0] ? 32'h0080_0000 : 32'h0000_0000)});
            repeat (PHASE_CYCLES - 4) drive_random();
        end
        drive_idle('0);
        drive_idle('0);
        @(negedge clk);
        #1;

        for (int m = 0; m < 4; m++) begin
            if (taken_by_mode[m] == 0) begin
                other_count++;
                $display("no exception was taken with BEV=%0d IV=%0d", m / 2, m % 2);
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/pipe_ctrl_pkg.sv
verilog/exc_collect.sv
verilog/cp0_regs.sv
verilog/pipe_ctrl.sv
verilog/exc_ctrl_top.sv
dv/exc_ctrl_chk.sv
dv/exc_ctrl_tb.sv

// ==== Makefile ====
# Verilator simulation of the exception and stall controller
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module exc_ctrl_tb -Mdir obj_dir -f files.f
	./obj_dir/Vexc_ctrl_tb | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
